/* verilog/udma_rx_pkg.sv */
// receive DMA shared definitions
// widths, item field types, memory map bases and the split FSM states
package udma_rx_pkg;

    localparam int AWIDTH     = 16;  // channel address inside the L2 window
    localparam int TRANS_SIZE = 16;  // byte counter width

    localparam int FIFO_DEPTH = 4;

    typedef logic [31:0]           data_t;
    typedef logic [31:0]           wdata_t;
    typedef logic [3:0]            be_t;
    typedef logic [31:0]           l2_addr_t;
    typedef logic [AWIDTH-1:0]     ch_addr_t;
    typedef logic [TRANS_SIZE-1:0] bytes_t;

    // item size, 0 byte, 1 halfword, 2 word
    typedef logic [1:0] size_t;

    // destination, 0 L2, 1 peripheral space, 2 cluster, 3 falls back to L2
    typedef logic [1:0] dest_t;

    //////////////////////////////////////////////////
    // memory map bases
    //////////////////////////////////////////////////
    localparam l2_addr_t L2_BASE  = 32'h1C00_0000;
    localparam l2_addr_t APB_BASE = 32'h1A10_0000;
    localparam l2_addr_t CLU_BASE = 32'h1000_0000;

    typedef enum logic
    {
        SPLIT_IDLE,
        SPLIT_SECOND
    } split_state_e;

endpackage

/* verilog/rx_ch_addrgen.sv */
// linear channel address generator
// walks the transfer window by item size and signals the end of transfer
module rx_ch_addrgen
(
    input  logic                  clk_i,
    input  logic                  rstn_i,

    input  udma_rx_pkg::ch_addr_t cfg_startaddr_i,
    input  udma_rx_pkg::bytes_t   cfg_size_i,
    input  logic                  cfg_continuous_i,
    input  logic                  cfg_en_i,
    input  logic                  cfg_clr_i,

    input  logic                  sample_i,
    input  udma_rx_pkg::size_t    size_i,

    output udma_rx_pkg::ch_addr_t curr_addr_o,
    output udma_rx_pkg::bytes_t   bytes_left_o,
    output logic                  en_o,
    output logic                  event_o
);

    udma_rx_pkg::ch_addr_t r_addr;
    udma_rx_pkg::bytes_t   r_bytes;
    logic                  r_en;

    udma_rx_pkg::bytes_t   s_inc;
    logic                  s_last;

    always_comb
    begin
        case (size_i)
            2'd0:    s_inc = udma_rx_pkg::bytes_t'(1);
            2'd1:    s_inc = udma_rx_pkg::bytes_t'(2);
            default: s_inc = udma_rx_pkg::bytes_t'(4);
        endcase
    end

    assign s_last = (r_bytes <= s_inc);  // a short tail also ends the window

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            r_addr  <= '0;
            r_bytes <= '0;
            r_en    <= 1'b0;
        end
        else if (cfg_clr_i)
        begin
            r_en <= 1'b0;
        end
        else if (cfg_en_i)
        begin
            r_addr  <= cfg_startaddr_i;
            r_bytes <= cfg_size_i;
            r_en    <= 1'b1;
        end
        else if (sample_i)
        begin
            if (s_last && cfg_continuous_i)
            begin
                r_addr  <= cfg_startaddr_i;  // restart the same window
                r_bytes <= cfg_size_i;
            end
            else
            begin
                r_addr  <= r_addr + udma_rx_pkg::ch_addr_t'(s_inc);
                r_bytes <= s_last ? '0 : r_bytes - s_inc;
                r_en    <= !s_last;
            end
        end
    end

    assign curr_addr_o  = r_addr;
    assign bytes_left_o = r_bytes;
    assign en_o         = r_en;
    assign event_o      = sample_i && s_last;

    // the core only grants channels that are enabled
    a_sample_when_en : assert property (@(posedge clk_i) disable iff (!rstn_i)
        sample_i |-> r_en);

endmodule

/* verilog/rx_arbiter.sv */
// round-robin arbiter over the channel requests
// the priority pointer moves only when the granted item is sampled
module rx_arbiter
#(
    parameter int N_CHANNELS = 4
)
(
    input  logic                  clk_i,
    input  logic                  rstn_i,

    input  logic [N_CHANNELS-1:0] req_i,
    input  logic                  ack_i,

    output logic [N_CHANNELS-1:0] grant_o,
    output logic                  any_grant_o
);

    localparam int IDX_W = $clog2(N_CHANNELS);

    logic [IDX_W-1:0] r_last;
    logic [IDX_W-1:0] s_sel;

    // search backwards so that the channel right after r_last wins
    always_comb
    begin
        int idx;
        grant_o = '0;
        s_sel   = r_last;
        for (int i = N_CHANNELS; i >= 1; i--)
        begin
            idx = (int'(r_last) + i) % N_CHANNELS;
            if (req_i[idx])
            begin
                grant_o      = '0;
                grant_o[idx] = 1'b1;
                s_sel        = IDX_W'(idx);
            end
        end
    end

    assign any_grant_o = |grant_o;

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            r_last <= IDX_W'(N_CHANNELS - 1);  // channel 0 first after reset
        else if (ack_i)
            r_last <= s_sel;
    end

    a_grant_onehot : assert property (@(posedge clk_i) disable iff (!rstn_i)
        $onehot0(grant_o));

endmodule

/* verilog/rx_req_fifo.sv */
// request queue between the sample register and the L2 write port
// room is reported one entry early to cover the item held in the sample register
module rx_req_fifo
(
    input  logic                  clk_i,
    input  logic                  rstn_i,

    input  logic                  push_i,
    input  udma_rx_pkg::data_t    data_i,
    input  udma_rx_pkg::size_t    size_i,
    input  udma_rx_pkg::dest_t    dest_i,
    input  udma_rx_pkg::ch_addr_t addr_i,

    input  logic                  pop_i,
    output logic                  valid_o,
    output udma_rx_pkg::data_t    data_o,
    output udma_rx_pkg::size_t    size_o,
    output udma_rx_pkg::dest_t    dest_o,
    output udma_rx_pkg::ch_addr_t addr_o,

    output logic                  room_o
);

    localparam int DEPTH = udma_rx_pkg::FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    udma_rx_pkg::data_t    mem_data [DEPTH];
    udma_rx_pkg::size_t    mem_size [DEPTH];
    udma_rx_pkg::dest_t    mem_dest [DEPTH];
    udma_rx_pkg::ch_addr_t mem_addr [DEPTH];

    logic [PTR_W-1:0] r_wr_ptr;
    logic [PTR_W-1:0] r_rd_ptr;
    logic [CNT_W-1:0] r_count;

    always_ff @(posedge clk_i)
    begin
        if (push_i)
        begin
            mem_data[r_wr_ptr] <= data_i;
            mem_size[r_wr_ptr] <= size_i;
            mem_dest[r_wr_ptr] <= dest_i;
            mem_addr[r_wr_ptr] <= addr_i;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_count  <= '0;
        end
        else
        begin
            if (push_i)
                r_wr_ptr <= r_wr_ptr + 1'b1;  // depth is a power of two
            if (pop_i)
                r_rd_ptr <= r_rd_ptr + 1'b1;
            case ({push_i, pop_i})
                2'b10:   r_count <= r_count + 1'b1;
                2'b01:   r_count <= r_count - 1'b1;
                default: r_count <= r_count;
            endcase
        end
    end

    assign valid_o = (r_count != '0);
    assign data_o  = mem_data[r_rd_ptr];
    assign size_o  = mem_size[r_rd_ptr];
    assign dest_o  = mem_dest[r_rd_ptr];
    assign addr_o  = mem_addr[r_rd_ptr];
    assign room_o  = (r_count < CNT_W'(DEPTH - 1));

    a_no_overflow : assert property (@(posedge clk_i) disable iff (!rstn_i)
        push_i |-> (r_count != CNT_W'(DEPTH)));

    a_no_underflow : assert property (@(posedge clk_i) disable iff (!rstn_i)
        pop_i |-> valid_o);

endmodule

/* verilog/rx_split_fsm.sv */
// split control for the L2 write port
// an item that crosses a word boundary is written with two granted beats
module rx_split_fsm
(
    input  logic               clk_i,
    input  logic               rstn_i,

    input  logic               valid_i,
    input  udma_rx_pkg::size_t size_i,
    input  logic [1:0]         offset_i,
    input  logic               l2_gnt_i,

    output logic               second_o,
    output logic               pop_o
);

    udma_rx_pkg::split_state_e r_state;
    udma_rx_pkg::split_state_e s_state_next;

    logic s_misaligned;

    // halfword at offset 3 or a word at any nonzero offset
    always_comb
    begin
        case (size_i)
            2'd1:    s_misaligned = (offset_i == 2'd3);
            2'd2:    s_misaligned = (offset_i != 2'd0);
            default: s_misaligned = 1'b0;
        endcase
    end

    always_comb
    begin
        s_state_next = r_state;
        pop_o        = 1'b0;
        case (r_state)
            udma_rx_pkg::SPLIT_IDLE:
            begin
                if (valid_i && l2_gnt_i)
                begin
                    if (s_misaligned)
                        s_state_next = udma_rx_pkg::SPLIT_SECOND;
                    else
                        pop_o = 1'b1;
                end
            end
            udma_rx_pkg::SPLIT_SECOND:
            begin
                if (valid_i && l2_gnt_i)
                begin
                    pop_o        = 1'b1;  // second beat retires the item
                    s_state_next = udma_rx_pkg::SPLIT_IDLE;
                end
            end
            default: s_state_next = udma_rx_pkg::SPLIT_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            r_state <= udma_rx_pkg::SPLIT_IDLE;
        else
            r_state <= s_state_next;
    end

    assign second_o = (r_state == udma_rx_pkg::SPLIT_SECOND);

endmodule

/* verilog/rx_lane_steer.sv */
// lane steering and address map for the current L2 beat
// byte enables and data follow the offset, the destination picks the base
module rx_lane_steer
(
    input  udma_rx_pkg::data_t    data_i,
    input  udma_rx_pkg::size_t    size_i,
    input  udma_rx_pkg::dest_t    dest_i,
    input  udma_rx_pkg::ch_addr_t addr_i,
    input  logic                  second_i,

    output udma_rx_pkg::be_t      be_o,
    output udma_rx_pkg::wdata_t   wdata_o,
    output udma_rx_pkg::l2_addr_t addr_o
);

    logic [1:0]            s_offset;
    logic [3:0]            s_ones;
    logic [7:0]            s_be_wide;
    logic [63:0]           s_data_wide;
    udma_rx_pkg::l2_addr_t s_base;
    udma_rx_pkg::l2_addr_t s_word_addr;
    udma_rx_pkg::l2_addr_t s_beat_inc;

    assign s_offset = addr_i[1:0];

    always_comb
    begin
        case (size_i)
            2'd0:    s_ones = 4'b0001;
            2'd1:    s_ones = 4'b0011;
            default: s_ones = 4'b1111;
        endcase
    end

    //////////////////////////////////////////////////
    // lanes over two words
    //////////////////////////////////////////////////

    // the upper half of each wide vector is what spills into the next word
    assign s_be_wide   = {4'b0000, s_ones} << s_offset;
    assign s_data_wide = {32'h0, data_i} << {s_offset, 3'b000};

    assign be_o    = second_i ? s_be_wide[7:4] : s_be_wide[3:0];
    assign wdata_o = second_i ? s_data_wide[63:32] : s_data_wide[31:0];

    //////////////////////////////////////////////////
    // address map
    //////////////////////////////////////////////////
    always_comb
    begin
        case (dest_i)
            2'd1:    s_base = udma_rx_pkg::APB_BASE;
            2'd2:    s_base = udma_rx_pkg::CLU_BASE;
            default: s_base = udma_rx_pkg::L2_BASE;
        endcase
    end

    assign s_word_addr = udma_rx_pkg::l2_addr_t'({addr_i[udma_rx_pkg::AWIDTH-1:2], 2'b00});
    assign s_beat_inc  = second_i ? udma_rx_pkg::l2_addr_t'(4) : '0;  // next word for the tail

    assign addr_o = s_base + s_word_addr + s_beat_inc;

endmodule

/* verilog/udma_rx_core.sv */
// receive DMA core for linear peripheral channels
// arbitrates channel data into a request queue that drains over a 32-bit L2 write port
module udma_rx_core
#(
    parameter int N_CHANNELS = 4,
    parameter int L2_AWIDTH  = udma_rx_pkg::AWIDTH
)
(
    input  logic                                     clk_i,
    input  logic                                     rstn_i,

    input  logic [N_CHANNELS-1:0]                    ch_valid_i,
    input  udma_rx_pkg::data_t [N_CHANNELS-1:0]      ch_data_i,
    input  udma_rx_pkg::size_t [N_CHANNELS-1:0]      ch_size_i,
    input  udma_rx_pkg::dest_t [N_CHANNELS-1:0]      ch_dest_i,
    output logic [N_CHANNELS-1:0]                    ch_ready_o,

    input  logic [N_CHANNELS-1:0][L2_AWIDTH-1:0]     ch_cfg_startaddr_i,
    input  udma_rx_pkg::bytes_t [N_CHANNELS-1:0]     ch_cfg_size_i,
    input  logic [N_CHANNELS-1:0]                    ch_cfg_continuous_i,
    input  logic [N_CHANNELS-1:0]                    ch_cfg_en_i,
    input  logic [N_CHANNELS-1:0]                    ch_cfg_clr_i,

    output logic [N_CHANNELS-1:0]                    ch_en_o,
    output logic [N_CHANNELS-1:0]                    ch_event_o,
    output logic [N_CHANNELS-1:0][L2_AWIDTH-1:0]     ch_curr_addr_o,
    output udma_rx_pkg::bytes_t [N_CHANNELS-1:0]     ch_bytes_left_o,

    output logic                                     l2_req_o,
    input  logic                                     l2_gnt_i,
    output udma_rx_pkg::l2_addr_t                    l2_addr_o,
    output udma_rx_pkg::be_t                         l2_be_o,
    output udma_rx_pkg::wdata_t                      l2_wdata_o
);

    logic [N_CHANNELS-1:0] s_req;
    logic [N_CHANNELS-1:0] s_grant;
    logic                  s_any_grant;
    logic                  s_room;
    logic                  s_sample;

    udma_rx_pkg::data_t    s_data;
    udma_rx_pkg::size_t    s_size;
    udma_rx_pkg::dest_t    s_dest;
    udma_rx_pkg::ch_addr_t s_addr;

    // sample register, pushed into the queue one cycle after the sample
    logic                  r_valid;
    udma_rx_pkg::data_t    r_data;
    udma_rx_pkg::size_t    r_size;
    udma_rx_pkg::dest_t    r_dest;
    udma_rx_pkg::ch_addr_t r_addr;

    logic                  s_q_valid;
    udma_rx_pkg::data_t    s_q_data;
    udma_rx_pkg::size_t    s_q_size;
    udma_rx_pkg::dest_t    s_q_dest;
    udma_rx_pkg::ch_addr_t s_q_addr;
    logic                  s_second;
    logic                  s_pop;

    //////////////////////////////////////////////////
    // channel side
    //////////////////////////////////////////////////
    assign s_req      = ch_valid_i & ch_en_o;
    assign s_sample   = s_any_grant && s_room;
    assign ch_ready_o = s_grant & {N_CHANNELS{s_room}};

    for (genvar j = 0; j < N_CHANNELS; j++)
    begin : g_ch
        rx_ch_addrgen i_addrgen
        (
            .clk_i            ( clk_i                  ),
            .rstn_i           ( rstn_i                 ),
            .cfg_startaddr_i  ( ch_cfg_startaddr_i[j]  ),
            .cfg_size_i       ( ch_cfg_size_i[j]       ),
            .cfg_continuous_i ( ch_cfg_continuous_i[j] ),
            .cfg_en_i         ( ch_cfg_en_i[j]         ),
            .cfg_clr_i        ( ch_cfg_clr_i[j]        ),
            .sample_i         ( ch_ready_o[j]          ),
            .size_i           ( ch_size_i[j]           ),
            .curr_addr_o      ( ch_curr_addr_o[j]      ),
            .bytes_left_o     ( ch_bytes_left_o[j]     ),
            .en_o             ( ch_en_o[j]             ),
            .event_o          ( ch_event_o[j]          )
        );
    end

    rx_arbiter #(.N_CHANNELS(N_CHANNELS)) i_arbiter
    (
        .clk_i       ( clk_i       ),
        .rstn_i      ( rstn_i      ),
        .req_i       ( s_req       ),
        .ack_i       ( s_sample    ),
        .grant_o     ( s_grant     ),
        .any_grant_o ( s_any_grant )
    );

    always_comb
    begin
        s_data = '0;
        s_size = '0;
        s_dest = '0;
        s_addr = '0;
        for (int i = 0; i < N_CHANNELS; i++)
        begin
            if (s_grant[i])
            begin
                s_data = ch_data_i[i];
                s_size = ch_size_i[i];
                s_dest = ch_dest_i[i];
                s_addr = ch_curr_addr_o[i];  // address before this item advances it
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            r_valid <= 1'b0;
        else
            r_valid <= s_sample;
    end

    always_ff @(posedge clk_i)
    begin
        if (s_sample)
        begin
            r_data <= s_data;
            r_size <= s_size;
            r_dest <= s_dest;
            r_addr <= s_addr;
        end
    end

    //////////////////////////////////////////////////
    // L2 side
    //////////////////////////////////////////////////
    rx_req_fifo i_req_fifo
    (
        .clk_i   ( clk_i     ),
        .rstn_i  ( rstn_i    ),
        .push_i  ( r_valid   ),
        .data_i  ( r_data    ),
        .size_i  ( r_size    ),
        .dest_i  ( r_dest    ),
        .addr_i  ( r_addr    ),
        .pop_i   ( s_pop     ),
        .valid_o ( s_q_valid ),
        .data_o  ( s_q_data  ),
        .size_o  ( s_q_size  ),
        .dest_o  ( s_q_dest  ),
        .addr_o  ( s_q_addr  ),
        .room_o  ( s_room    )
    );

    rx_split_fsm i_split_fsm
    (
        .clk_i    ( clk_i          ),
        .rstn_i   ( rstn_i         ),
        .valid_i  ( s_q_valid      ),
        .size_i   ( s_q_size       ),
        .offset_i ( s_q_addr[1:0]  ),
        .l2_gnt_i ( l2_gnt_i       ),
        .second_o ( s_second       ),
        .pop_o    ( s_pop          )
    );

    rx_lane_steer i_lane_steer
    (
        .data_i   ( s_q_data   ),
        .size_i   ( s_q_size   ),
        .dest_i   ( s_q_dest   ),
        .addr_i   ( s_q_addr   ),
        .second_i ( s_second   ),
        .be_o     ( l2_be_o    ),
        .wdata_o  ( l2_wdata_o ),
        .addr_o   ( l2_addr_o  )
    );

    assign l2_req_o = s_q_valid;

    // a pending request keeps its beat until the grant
    a_l2_stable : assert property (@(posedge clk_i) disable iff (!rstn_i)
        l2_req_o && !l2_gnt_i |=> l2_req_o && $stable(l2_addr_o) && $stable(l2_be_o)
            && $stable(l2_wdata_o));

endmodule

/* sim/tb_udma_rx_core.sv */
// testbench for the receive DMA core
// table driven channel traffic checked against a beat level model of the L2 port
module tb_udma_rx_core;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_CH       = 4;
    localparam int N_ROWS     = 8;
    localparam int N_GROUPS   = 3;
    localparam int MAX_CYCLES = 400;

    typedef struct packed
    {
        udma_rx_pkg::l2_addr_t addr;
        udma_rx_pkg::be_t      be;
        udma_rx_pkg::wdata_t   wdata;
    } beat_t;

    logic                               clk = 1'b0;
    logic                               rstn;
    logic [N_CH-1:0]                    ch_valid;
    udma_rx_pkg::data_t [N_CH-1:0]      ch_data;
    udma_rx_pkg::size_t [N_CH-1:0]      ch_size;
    udma_rx_pkg::dest_t [N_CH-1:0]      ch_dest;
    logic [N_CH-1:0]                    ch_ready;
    udma_rx_pkg::ch_addr_t [N_CH-1:0]   cfg_startaddr;
    udma_rx_pkg::bytes_t [N_CH-1:0]     cfg_size;
    logic [N_CH-1:0]                    cfg_cont;
    logic [N_CH-1:0]                    cfg_en;
    logic [N_CH-1:0]                    cfg_clr;
    logic [N_CH-1:0]                    ch_en;
    logic [N_CH-1:0]                    ch_event;
    udma_rx_pkg::ch_addr_t [N_CH-1:0]   ch_curr_addr;
    udma_rx_pkg::bytes_t [N_CH-1:0]     ch_bytes_left;
    logic                               l2_req;
    logic                               l2_gnt;
    udma_rx_pkg::l2_addr_t              l2_addr;
    udma_rx_pkg::be_t                   l2_be;
    udma_rx_pkg::wdata_t                l2_wdata;

    // item k of a table row takes its size from row_sizes[2k+1:2k]
    int                    row_grp   [N_ROWS];
    int                    row_ch    [N_ROWS];
    udma_rx_pkg::ch_addr_t row_start [N_ROWS];
    udma_rx_pkg::bytes_t   row_count [N_ROWS];
    logic                  row_cont  [N_ROWS];
    udma_rx_pkg::dest_t    row_dest  [N_ROWS];
    int                    row_n     [N_ROWS];
    logic [15:0]           row_sizes [N_ROWS];
    udma_rx_pkg::data_t    row_data  [N_ROWS];
    int                    n_rows = 0;

    udma_rx_pkg::ch_addr_t m_addr   [N_CH];
    udma_rx_pkg::bytes_t   m_bytes  [N_CH];
    logic                  m_en     [N_CH];
    int                    act_row  [N_CH];  // -1 while the channel is idle
    int                    item_idx [N_CH];
    beat_t                 exp_q    [N_CH][$];
    int                    tag_q    [$];     // channel of every expected beat in sample order
    logic [31:0]           lfsr = 32'h6f95_55eb;

    udma_rx_core #(.N_CHANNELS(N_CH)) i_udma_rx_core
    (
        .clk_i               ( clk           ),
        .rstn_i              ( rstn          ),
        .ch_valid_i          ( ch_valid      ),
        .ch_data_i           ( ch_data       ),
        .ch_size_i           ( ch_size       ),
        .ch_dest_i           ( ch_dest       ),
        .ch_ready_o          ( ch_ready      ),
        .ch_cfg_startaddr_i  ( cfg_startaddr ),
        .ch_cfg_size_i       ( cfg_size      ),
        .ch_cfg_continuous_i ( cfg_cont      ),
        .ch_cfg_en_i         ( cfg_en        ),
        .ch_cfg_clr_i        ( cfg_clr       ),
        .ch_en_o             ( ch_en         ),
        .ch_event_o          ( ch_event      ),
        .ch_curr_addr_o      ( ch_curr_addr  ),
        .ch_bytes_left_o     ( ch_bytes_left ),
        .l2_req_o            ( l2_req        ),
        .l2_gnt_i            ( l2_gnt        ),
        .l2_addr_o           ( l2_addr       ),
        .l2_be_o             ( l2_be         ),
        .l2_wdata_o          ( l2_wdata      )
    );

    always #2 clk = ~clk;

    //////////////////////////////////////////////////
    // compare helpers
    //////////////////////////////////////////////////
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_addr(input string name, input udma_rx_pkg::l2_addr_t got,
                              input udma_rx_pkg::l2_addr_t exp);
        if (got !== exp)
            report_failure($sformatf("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp));
    endtask

    task automatic check_ch_addr(input string name, input udma_rx_pkg::ch_addr_t got,
                                 input udma_rx_pkg::ch_addr_t exp);
        if (got !== exp)
            report_failure($sformatf("MISMATCH %s: got 0x%04h expected 0x%04h", name, got, exp));
    endtask

    task automatic check_be(input string name, input udma_rx_pkg::be_t got,
                            input udma_rx_pkg::be_t exp);
        if (got !== exp)
            report_failure($sformatf("MISMATCH %s: got 0x%01h expected 0x%01h", name, got, exp));
    endtask

    task automatic check_wdata(input string name, input udma_rx_pkg::wdata_t got,
                               input udma_rx_pkg::wdata_t exp);
        if (got !== exp)
            report_failure($sformatf("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp));
    endtask

    task automatic check_bytes(input string name, input udma_rx_pkg::bytes_t got,
                               input udma_rx_pkg::bytes_t exp);
        if (got !== exp)
            report_failure($sformatf("MISMATCH %s: got 0x%04h expected 0x%04h", name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_failure($sformatf("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic int item_size_bytes(input udma_rx_pkg::size_t s);
        item_size_bytes = (s == 2'd0) ? 1 : (s == 2'd1) ? 2 : 4;
    endfunction

    task automatic add_row(input int grp, input int ch, input udma_rx_pkg::ch_addr_t start,
                           input udma_rx_pkg::bytes_t count, input logic cont,
                           input udma_rx_pkg::dest_t dest, input int n,
                           input logic [15:0] sizes, input udma_rx_pkg::data_t data);
        row_grp[n_rows]   = grp;
        row_ch[n_rows]    = ch;
        row_start[n_rows] = start;
        row_count[n_rows] = count;
        row_cont[n_rows]  = cont;
        row_dest[n_rows]  = dest;
        row_n[n_rows]     = n;
        row_sizes[n_rows] = sizes;
        row_data[n_rows]  = data;
        n_rows++;
    endtask

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////
    task automatic predict_beats(input int ch, input udma_rx_pkg::ch_addr_t a,
                                 input udma_rx_pkg::size_t s, input udma_rx_pkg::dest_t d,
                                 input udma_rx_pkg::data_t data);
        logic [1:0]            off;
        udma_rx_pkg::be_t      ones;
        udma_rx_pkg::l2_addr_t base;
        udma_rx_pkg::l2_addr_t waddr;
        beat_t                 b;
        off  = a[1:0];
        ones = (s == 2'd0) ? 4'b0001 : (s == 2'd1) ? 4'b0011 : 4'b1111;
        case (d)
            2'd1:    base = udma_rx_pkg::APB_BASE;
            2'd2:    base = udma_rx_pkg::CLU_BASE;
            default: base = udma_rx_pkg::L2_BASE;
        endcase
        waddr   = base + udma_rx_pkg::l2_addr_t'({a[udma_rx_pkg::AWIDTH-1:2], 2'b00});
        b.addr  = waddr;
        b.be    = ones << off;
        b.wdata = data << (8 * off);
        exp_q[ch].push_back(b);
        tag_q.push_back(ch);
        // bytes that run past lane 3 go out in a second beat at the next word
        if (int'(off) + item_size_bytes(s) > 4)
        begin
            b.addr  = waddr + 32'd4;
            b.be    = ones >> (4 - off);
            b.wdata = data >> (8 * (4 - off));
            exp_q[ch].push_back(b);
            tag_q.push_back(ch);
        end
    endtask

    task automatic match_beat();
        int    ch;
        int    pos;
        beat_t exp;
        ch  = int'(l2_addr[15:12]);  // windows sit at 0x1000 times the channel
        pos = -1;
        if (ch >= N_CH)
        begin
            if (tag_q.size() == 0)
                report_failure("L2 write seen while no beat was expected");
            ch = tag_q[0];
        end
        for (int i = 0; i < tag_q.size(); i++)
            if (pos < 0 && tag_q[i] == ch)
                pos = i;
        if (pos < 0 || exp_q[ch].size() == 0)
            report_failure($sformatf("L2 write for channel %0d that was never sampled", ch));
        tag_q.delete(pos);
        exp = exp_q[ch].pop_front();
        check_addr("l2_addr_o", l2_addr, exp.addr);
        check_be("l2_be_o", l2_be, exp.be);
        check_wdata("l2_wdata_o", l2_wdata, exp.wdata);
    endtask

    //////////////////////////////////////////////////
    // per cycle drive and observe
    //////////////////////////////////////////////////
    task automatic drive_cycle();
        int r;
        lfsr   = lfsr_next(lfsr);
        l2_gnt = lfsr[0];
        for (int c = 0; c < N_CH; c++)
        begin
            r = act_row[c];
            if (r >= 0 && item_idx[c] < row_n[r])
            begin
                ch_valid[c] = 1'b1;
                ch_size[c]  = row_sizes[r][2*item_idx[c] +: 2];
                ch_dest[c]  = row_dest[r];
                ch_data[c]  = row_data[r] ^ {4{8'(item_idx[c])}};
            end
            else
                ch_valid[c] = 1'b0;
        end
    endtask

    task automatic observe_cycle();
        int   r;
        int   inc;
        logic last;
        if (l2_req && l2_gnt)
            match_beat();
        for (int c = 0; c < N_CH; c++)
        begin
            check_bytes($sformatf("ch_bytes_left_o[%0d]", c), ch_bytes_left[c], m_bytes[c]);
            check_ch_addr($sformatf("ch_curr_addr_o[%0d]", c), ch_curr_addr[c], m_addr[c]);
            check_flag($sformatf("ch_en_o[%0d]", c), ch_en[c], m_en[c]);
            inc  = item_size_bytes(ch_size[c]);
            last = (int'(m_bytes[c]) <= inc);
            check_flag($sformatf("ch_event_o[%0d]", c), ch_event[c], ch_ready[c] && last);
            if (ch_ready[c] && !ch_valid[c])
                report_failure($sformatf("channel %0d was made ready without valid data", c));
            if (ch_ready[c])
            begin
                r = act_row[c];
                predict_beats(c, m_addr[c], ch_size[c], ch_dest[c], ch_data[c]);
                if (last && row_cont[r])
                begin
                    m_addr[c]  = row_start[r];
                    m_bytes[c] = row_count[r];
                end
                else if (last)
                begin
                    m_addr[c]  = m_addr[c] + udma_rx_pkg::ch_addr_t'(inc);
                    m_bytes[c] = '0;
                    m_en[c]    = 1'b0;
                end
                else
                begin
                    m_addr[c]  = m_addr[c] + udma_rx_pkg::ch_addr_t'(inc);
                    m_bytes[c] = m_bytes[c] - udma_rx_pkg::bytes_t'(inc);
                end
                item_idx[c]++;
            end
        end
    endtask

    task automatic start_group(input int g);
        int c;
        @(negedge clk);
        for (int r = 0; r < n_rows; r++)
        begin
            if (row_grp[r] == g)
            begin
                c                = row_ch[r];
                cfg_startaddr[c] = row_start[r];
                cfg_size[c]      = row_count[r];
                cfg_cont[c]      = row_cont[r];
                cfg_en[c]        = 1'b1;
                act_row[c]       = r;
                item_idx[c]      = 0;
                m_addr[c]        = row_start[r];
                m_bytes[c]       = row_count[r];
                m_en[c]          = 1'b1;
            end
        end
        @(negedge clk);
        cfg_en = '0;
    endtask

    task automatic run_group(input int g);
        int   cycles;
        logic busy;
        cycles = 0;
        busy   = 1'b1;
        while (busy)
        begin
            drive_cycle();
            #1;
            observe_cycle();
            cycles++;
            if (cycles > MAX_CYCLES)
                report_failure($sformatf("group %0d did not drain within %0d cycles", g, cycles));
            busy = (tag_q.size() != 0);
            for (int c = 0; c < N_CH; c++)
                if (act_row[c] >= 0 && item_idx[c] < row_n[act_row[c]])
                    busy = 1'b1;
            @(negedge clk);
        end
        ch_valid = '0;
    endtask

    // continuous channels keep running until they are cleared
    task automatic end_group();
        for (int c = 0; c < N_CH; c++)
        begin
            if (act_row[c] >= 0 && row_cont[act_row[c]])
            begin
                cfg_clr[c] = 1'b1;
                m_en[c]    = 1'b0;
            end
            act_row[c] = -1;
        end
        @(negedge clk);
        cfg_clr = '0;
        #1;
        for (int c = 0; c < N_CH; c++)
            check_flag($sformatf("ch_en_o[%0d]", c), ch_en[c], m_en[c]);
    endtask

    initial
    begin
        rstn          = 1'b0;
        ch_valid      = '0;
        ch_data       = '0;
        ch_size       = '0;
        ch_dest       = '0;
        cfg_startaddr = '0;
        cfg_size      = '0;
        cfg_cont      = '0;
        cfg_en        = '0;
        cfg_clr       = '0;
        l2_gnt        = 1'b0;
        for (int c = 0; c < N_CH; c++)
        begin
            act_row[c]  = -1;
            item_idx[c] = 0;
            m_addr[c]   = '0;
            m_bytes[c]  = '0;
            m_en[c]     = 1'b0;
        end

        add_row(0, 0, 16'h0100, 16'd16, 1'b0, 2'd0, 4, 16'h00aa, 32'h4433_2211);
        add_row(1, 1, 16'h1201, 16'd12, 1'b0, 2'd1, 8, 16'h5014, 32'ha1b2_c3d4);
        add_row(1, 2, 16'h2301, 16'd16, 1'b0, 2'd2, 6, 16'h0622, 32'h8765_4321);
        add_row(2, 3, 16'h3400, 16'd8,  1'b1, 2'd3, 4, 16'h00aa, 32'hcafe_0f0f);
        add_row(2, 0, 16'h0140, 16'd12, 1'b0, 2'd0, 3, 16'h002a, 32'h1357_9bdf);
        add_row(2, 1, 16'h1302, 16'd8,  1'b0, 2'd2, 4, 16'h0055, 32'h2468_ace0);

        repeat (10) @(negedge clk);
        check_flag("l2_req_o", l2_req, 1'b0);
        for (int c = 0; c < N_CH; c++)
        begin
            check_flag($sformatf("ch_ready_o[%0d]", c), ch_ready[c], 1'b0);
            check_flag($sformatf("ch_event_o[%0d]", c), ch_event[c], 1'b0);
            check_flag($sformatf("ch_en_o[%0d]", c), ch_en[c], 1'b0);
        end
        rstn = 1'b1;

        for (int g = 0; g < N_GROUPS; g++)
        begin
            start_group(g);
            run_group(g);
            end_group();
        end

        $display("All checks passed");
        $finish;
    end

endmodule

/* sim.f */
verilog/udma_rx_pkg.sv
verilog/rx_ch_addrgen.sv
verilog/rx_arbiter.sv
verilog/rx_req_fifo.sv
verilog/rx_split_fsm.sv
verilog/rx_lane_steer.sv
verilog/udma_rx_core.sv
sim/tb_udma_rx_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the receive DMA testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_udma_rx_core -f sim.f -o tb_sim \
    || { echo "build failed"; exit 1; }

out="$(./obj_dir/tb_sim)"
echo "$out"
echo "$out" | grep -qx "All checks passed" && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }
